/* list.f */
source/isaPkg.sv
source/coreCtrlPkg.sv
source/instDecode.sv
source/regFile.sv
source/aluUnit.sv
source/nextPcUnit.sv
source/wordMemory.sv
source/wiscCore.sv
verif/commitChecker.sv
verif/coreTb.sv

/* source/aluUnit.sv */
/*
 * Arithmetic, logic and shift unit. Also reports whether the rs
 * operand is zero or negative for the conditional branches.
 */
module aluUnit import isaPkg::*, coreCtrlPkg::*; (
   input  logic [dataWidth-1:0] inA,
   input  logic [dataWidth-1:0] inB,
   input  aluOpT                op,
   output logic [dataWidth-1:0] result,
   output logic                 zero,
   output logic                 negative
);

   logic [3:0] shAmt;

   assign shAmt = inB[3:0];

   always_comb begin
      case (op)
         aluAdd:  result = inA + inB;
         // ISA defines SUB as rt minus rs
         aluSub:  result = inB - inA;
         aluXor:  result = inA ^ inB;
         aluAndn: result = inA & ~inB;
         aluSll:  result = inA << shAmt;
         aluSrl:  result = inA >> shAmt;
         aluPassB: result = inB;
         aluShiftLoad: result = (inA << 8) | inB;
         default: result = '0;
      endcase
   end

   // Flags look at rs itself, not the result
   assign zero     = (inA == '0);
   assign negative = inA[dataWidth-1];

endmodule

/* source/coreCtrlPkg.sv */
/*
 * Control definitions of the core: ALU operations, immediate
 * extension modes, destination and branch selects, and the decoded
 * control word passed from the decoder to the datapath.
 */
package coreCtrlPkg;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluXor,
      aluAndn,
      aluSll,
      aluSrl,
      aluPassB,
      // SLBI shifts rs up a byte and ors in the immediate
      aluShiftLoad
   } aluOpT;

   typedef enum logic [2:0] {
      zero5,
      sign5,
      zero8,
      sign8,
      sign11
   } extSelT;

   typedef enum logic [1:0] {
      rdField,
      rtField,
      rsField,
      link7
   } regDstT;

   typedef enum logic [2:0] {
      brNone,
      brEqz,
      brNez,
      brLtz,
      brGez,
      brJumpImm,
      brJumpReg
   } branchT;

   typedef struct packed {
      aluOpT  aluOp;
      extSelT extSel;
      regDstT regDst;
      branchT branch;
      logic   useImm;
      logic   regWrite;
      logic   memRead;
      logic   memWrite;
      logic   linkWrite;
      logic   halt;
      logic   illegal;
   } ctrlT;

endpackage

/* source/instDecode.sv */
/*
 * Instruction decoder. Maps the opcode, and the function field of
 * the register groups, onto the control word; unknown encodings
 * are flagged illegal with all writes off.
 */
module instDecode import isaPkg::*, coreCtrlPkg::*; (
   input  instWordT inst,
   output ctrlT     ctrl
);

   always_comb begin
      // Defaults describe a NOP
      ctrl = '{aluOp: aluAdd, extSel: sign5, regDst: rdField, branch: brNone,
               default: 1'b0};

      case (inst.r.opcode)
         opHalt: ctrl.halt = 1'b1;
         opNop: ;
         opAddi, opSubi, opXori, opAndni: begin
            ctrl.useImm   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = rtField;
            case (inst.r.opcode)
               opAddi:  ctrl.aluOp = aluAdd;
               opSubi:  ctrl.aluOp = aluSub;
               opXori:  ctrl.aluOp = aluXor;
               default: ctrl.aluOp = aluAndn;
            endcase
            // Logic immediates zero-extend
            ctrl.extSel = (inst.r.opcode inside {opXori, opAndni}) ? zero5 : sign5;
         end
         opLbi, opSlbi: begin
            ctrl.useImm   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = rsField;
            ctrl.aluOp    = (inst.r.opcode == opLbi) ? aluPassB : aluShiftLoad;
            ctrl.extSel   = (inst.r.opcode == opLbi) ? sign8 : zero8;
         end
         opLd: begin
            ctrl.useImm   = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.memRead  = 1'b1;
            ctrl.regDst   = rtField;
         end
         opSt: begin
            ctrl.useImm   = 1'b1;
            ctrl.memWrite = 1'b1;
         end
         opBeqz: ctrl.branch = brEqz;
         opBnez: ctrl.branch = brNez;
         opBltz: ctrl.branch = brLtz;
         opBgez: ctrl.branch = brGez;
         opJ: begin
            ctrl.branch = brJumpImm;
            ctrl.extSel = sign11;
         end
         opJal: begin
            ctrl.branch    = brJumpImm;
            ctrl.extSel    = sign11;
            ctrl.regDst    = link7;
            ctrl.regWrite  = 1'b1;
            ctrl.linkWrite = 1'b1;
         end
         opJr: ctrl.branch = brJumpReg;
         opAluReg: begin
            ctrl.regWrite = 1'b1;
            case (inst.r.funct)
               functAdd: ctrl.aluOp = aluAdd;
               functSub: ctrl.aluOp = aluSub;
               functXor: ctrl.aluOp = aluXor;
               default:  ctrl.aluOp = aluAndn;
            endcase
         end
         opShiftReg: begin
            if (inst.r.funct == functSll || inst.r.funct == functSrl) begin
               ctrl.regWrite = 1'b1;
               ctrl.aluOp    = (inst.r.funct == functSll) ? aluSll : aluSrl;
            end else begin
               ctrl.illegal = 1'b1;
            end
         end
         default: ctrl.illegal = 1'b1;
      endcase

      // Branches and JR all take an 8-bit signed offset
      if (ctrl.branch inside {brEqz, brNez, brLtz, brGez, brJumpReg})
         ctrl.extSel = sign8;
   end

endmodule

/* source/isaPkg.sv */
/*
 * Instruction-set definitions for the 16-bit teaching core.
 * Holds the data and memory sizes, the opcodes and function codes,
 * the two views of an instruction word and the records that cross
 * the core boundary.
 */
package isaPkg;

   localparam int dataWidth    = 16;
   localparam int regAddrWidth = 3;
   localparam int memWords     = 256;
   // Word index taken from byte address bits 8..1
   localparam int memAddrWidth = 8;

   // Function codes of the register ALU group
   localparam logic [1:0] functAdd  = 2'b00;
   localparam logic [1:0] functSub  = 2'b01;
   localparam logic [1:0] functXor  = 2'b10;
   localparam logic [1:0] functAndn = 2'b11;
   // Function codes of the shift group (no rotates)
   localparam logic [1:0] functSll  = 2'b01;
   localparam logic [1:0] functSrl  = 2'b11;

   typedef enum logic [4:0] {
      opHalt     = 5'b00000,
      opNop      = 5'b00001,
      opJ        = 5'b00100,
      opJr       = 5'b00101,
      opJal      = 5'b00110,
      opAddi     = 5'b01000,
      opSubi     = 5'b01001,
      opXori     = 5'b01010,
      opAndni    = 5'b01011,
      opBeqz     = 5'b01100,
      opBnez     = 5'b01101,
      opBltz     = 5'b01110,
      opBgez     = 5'b01111,
      opSt       = 5'b10000,
      opLd       = 5'b10001,
      opSlbi     = 5'b10010,
      opLbi      = 5'b11000,
      opShiftReg = 5'b11010,
      opAluReg   = 5'b11011
   } opcodeT;

   typedef struct packed {
      opcodeT                  opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [regAddrWidth-1:0] rd;
      logic [1:0]              funct;
   } regFormatT;

   // Immediates sit at the low end; the top 3 bits overlap rs
   typedef struct packed {
      opcodeT      opcode;
      logic [10:0] imm;
   } immFormatT;

   typedef union packed {
      regFormatT r;
      immFormatT i;
   } instWordT;

   typedef struct packed {
      logic                    valid;
      logic [memAddrWidth-1:0] addr;
      logic [dataWidth-1:0]    data;
   } progLoadT;

   typedef struct packed {
      logic                    valid;
      logic [dataWidth-1:0]    pc;
      logic                    regWrite;
      logic [regAddrWidth-1:0] regIndex;
      logic [dataWidth-1:0]    regData;
      logic                    memWrite;
      logic [dataWidth-1:0]    memAddr;
      logic [dataWidth-1:0]    memData;
      logic                    halt;
   } retireT;

endpackage

/* source/nextPcUnit.sv */
/*
 * Program counter. Forms PC+2 and the branch and jump targets,
 * picks the next PC and holds it once the core halts.
 */
module nextPcUnit import isaPkg::*, coreCtrlPkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 halt,
   input  branchT               branch,
   input  logic                 zero,
   input  logic                 negative,
   input  logic [dataWidth-1:0] imm,
   input  logic [dataWidth-1:0] regTarget,
   output logic [dataWidth-1:0] pc,
   output logic [dataWidth-1:0] pcPlus2
);

   logic                 taken;
   logic [dataWidth-1:0] nextPc;

   assign pcPlus2 = pc + dataWidth'(2);

   always_comb begin
      case (branch)
         brEqz:     taken = zero;
         brNez:     taken = !zero;
         brLtz:     taken = negative;
         brGez:     taken = !negative;
         brJumpImm: taken = 1'b1;
         default:   taken = 1'b0;
      endcase
   end

   always_comb begin
      if (branch == brJumpReg)
         nextPc = regTarget + imm;
      else if (taken)
         nextPc = pcPlus2 + imm;
      else
         nextPc = pcPlus2;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (!halt) begin
         pc <= nextPc;
      end
   end

   // Odd targets from a bad offset or JR base would break fetch
   pcEven: assert property (@(posedge clk) disable iff (reset) !pc[0])
      else $error("PC became odd: %h", pc);

endmodule

/* source/regFile.sv */
/*
 * Eight-entry register file with two combinational read ports
 * and one write port that lands on the rising clock edge.
 */
module regFile import isaPkg::*; (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [regAddrWidth-1:0] readSel1,
   input  logic [regAddrWidth-1:0] readSel2,
   input  logic [regAddrWidth-1:0] writeSel,
   input  logic [dataWidth-1:0]    writeData,
   input  logic                    writeEn,
   output logic [dataWidth-1:0]    readData1,
   output logic [dataWidth-1:0]    readData2
);

   logic [dataWidth-1:0] regs [1 << regAddrWidth];

   always_ff @(posedge clk) begin
      if (reset) begin
         regs <= '{default: '0};
      end else if (writeEn) begin
         regs[writeSel] <= writeData;
      end
   end

   // Single-cycle core, so no write-to-read forwarding
   assign readData1 = regs[readSel1];
   assign readData2 = regs[readSel2];

   // Core must keep writes off while held in reset
   noWriteInReset: assert property (@(posedge clk) reset |-> !writeEn)
      else $error("register write requested during reset");

endmodule

/* source/wiscCore.sv */
/*
 * Single-cycle 16-bit core. Fetches, decodes, executes and retires
 * one instruction per clock, reports it on the retire trace and
 * flags illegal opcodes and misaligned accesses on err.
 */
module wiscCore import isaPkg::*, coreCtrlPkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  progLoadT progLoad,
   output retireT   retire,
   output logic     halted,
   output logic     err
);

   logic [dataWidth-1:0]    pc, pcPlus2, immExt;
   logic [dataWidth-1:0]    rsData, rtData, aluInB, aluResult, memData, writeData;
   logic [regAddrWidth-1:0] writeSel;
   logic                    zero, negative, active, misaligned;
   logic                    loadEn, rfWriteEn, dmWriteEn;
   instWordT                inst;
   ctrlT                    ctrl;

   assign active = !reset && !halted;

   nextPcUnit pcUnit (
      .clk(clk), .reset(reset), .halt(halted || ctrl.halt), .branch(ctrl.branch),
      .zero(zero), .negative(negative), .imm(immExt), .regTarget(rsData),
      .pc(pc), .pcPlus2(pcPlus2));

   // Program loader owns the instruction write port during reset
   assign loadEn = reset && progLoad.valid;

   wordMemory instMem (
      .clk(clk), .writeEn(loadEn), .writeAddr(progLoad.addr),
      .readAddr(pc[memAddrWidth:1]), .writeData(progLoad.data), .readData(inst));

   instDecode decode (.inst(inst), .ctrl(ctrl));

   always_comb begin
      case (ctrl.extSel)
         zero5:   immExt = {{(dataWidth-5){1'b0}}, inst.i.imm[4:0]};
         sign5:   immExt = {{(dataWidth-5){inst.i.imm[4]}}, inst.i.imm[4:0]};
         zero8:   immExt = {{(dataWidth-8){1'b0}}, inst.i.imm[7:0]};
         sign8:   immExt = {{(dataWidth-8){inst.i.imm[7]}}, inst.i.imm[7:0]};
         default: immExt = {{(dataWidth-11){inst.i.imm[10]}}, inst.i.imm};
      endcase
   end

   always_comb begin
      case (ctrl.regDst)
         rdField: writeSel = inst.r.rd;
         rtField: writeSel = inst.r.rt;
         rsField: writeSel = inst.r.rs;
         default: writeSel = regAddrWidth'(7);
      endcase
   end

   regFile regs (
      .clk(clk), .reset(reset), .readSel1(inst.r.rs), .readSel2(inst.r.rt),
      .writeSel(writeSel), .writeData(writeData), .writeEn(rfWriteEn),
      .readData1(rsData), .readData2(rtData));

   assign aluInB = ctrl.useImm ? immExt : rtData;

   aluUnit alu (
      .inA(rsData), .inB(aluInB), .op(ctrl.aluOp), .result(aluResult),
      .zero(zero), .negative(negative));

   // Word accesses only; an odd address faults and writes nothing
   assign misaligned = (ctrl.memRead || ctrl.memWrite) && aluResult[0];
   assign dmWriteEn  = ctrl.memWrite && active && !misaligned;
   assign rfWriteEn  = ctrl.regWrite && active && !misaligned;

   wordMemory dataMem (
      .clk(clk), .writeEn(dmWriteEn), .writeAddr(aluResult[memAddrWidth:1]),
      .readAddr(aluResult[memAddrWidth:1]), .writeData(rtData), .readData(memData));

   assign writeData = ctrl.linkWrite ? pcPlus2 : (ctrl.memRead ? memData : aluResult);

   always_ff @(posedge clk) begin
      if (reset) begin
         halted <= 1'b0;
      end else if (ctrl.halt) begin
         halted <= 1'b1;
      end
   end

   assign err = (ctrl.illegal || misaligned) && active;

   always_comb begin
      retire.valid    = active;
      retire.pc       = pc;
      retire.regWrite = rfWriteEn;
      retire.regIndex = writeSel;
      retire.regData  = writeData;
      retire.memWrite = dmWriteEn;
      retire.memAddr  = aluResult;
      retire.memData  = rtData;
      retire.halt     = ctrl.halt && active;
   end

endmodule

/* source/wordMemory.sv */
/*
 * Word-organized memory with one combinational read port and one
 * synchronous write port. Serves as instruction and data memory.
 */
module wordMemory import isaPkg::*; (
   input  logic                    clk,
   input  logic                    writeEn,
   input  logic [memAddrWidth-1:0] writeAddr,
   input  logic [memAddrWidth-1:0] readAddr,
   input  logic [dataWidth-1:0]    writeData,
   output logic [dataWidth-1:0]    readData
);

   logic [dataWidth-1:0] mem [memWords];

   always_ff @(posedge clk) begin
      if (writeEn) begin
         mem[writeAddr] <= writeData;
      end
   end

   assign readData = mem[readAddr];

endmodule

/* verif/commitChecker.sv */
/*
 * Retire-trace checker for the core testbench. Mirrors the
 * register file from the retire records, checks the halt and store
 * fields of each record, counts retired instructions and compares
 * them with each case's expected results once the core halts.
 */
module commitChecker import isaPkg::*; (
   input  logic                       clk,
   input  logic                       reset,
   input  retireT                     retire,
   input  logic                       halted,
   input  logic                       err,
   input  logic [127:0]               caseName,
   input  logic [15:0][dataWidth-1:0] prog,
   input  logic [7:0][dataWidth-1:0]  expRegs,
   input  int                         expCount,
   input  logic                       expErr,
   output logic                       caseDone,
   output int                         passCount,
   output int                         failCount
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [dataWidth-1:0] mirror [8];
   int                   retired;
   int                   traceBad;
   logic                 sawErr;

   initial begin
      passCount = 0;
      failCount = 0;
      caseDone = 1'b0;
   end

   // Halt and store fields against the ISA meaning of the word at the retired PC
   task automatic checkRecord();
      logic [dataWidth-1:0] word;
      logic [dataWidth-1:0] addr;
      logic                 isHalt;
      logic                 isStore;
      if (retired == 0 && retire.pc !== '0) begin
         $display("[ERROR] %0s first retired pc expected %h actual %h",
                  caseName, 16'h0000, retire.pc);
         traceBad++;
      end
      if (retire.pc[0] || retire.pc[dataWidth-1:5] != '0) begin
         $display("%0s: instruction retired at %h, outside the loaded program",
                  caseName, retire.pc);
         traceBad++;
      end else begin
         word    = prog[retire.pc[4:1]];
         addr    = mirror[word[10:8]] + {{(dataWidth-5){word[4]}}, word[4:0]};
         isHalt  = (word[15:11] == opHalt);
         isStore = (word[15:11] == opSt) && !addr[0];
         if (retire.halt !== isHalt) begin
            $display("[ERROR] %0s halt flag at pc %h expected %b actual %b",
                     caseName, retire.pc, isHalt, retire.halt);
            traceBad++;
         end
         if (retire.memWrite !== isStore) begin
            $display("[ERROR] %0s store flag at pc %h expected %b actual %b",
                     caseName, retire.pc, isStore, retire.memWrite);
            traceBad++;
         end else if (isStore && retire.memAddr !== addr) begin
            $display("[ERROR] %0s store address at pc %h expected %h actual %h",
                     caseName, retire.pc, addr, retire.memAddr);
            traceBad++;
         end else if (isStore && retire.memData !== mirror[word[7:5]]) begin
            $display("[ERROR] %0s store data at pc %h expected %h actual %h",
                     caseName, retire.pc, mirror[word[7:5]], retire.memData);
            traceBad++;
         end
      end
   endtask

   task automatic checkCase();
      int bad;
      bad = traceBad;
      for (int r = 0; r < 8; r++) begin
         if (mirror[r] !== expRegs[r]) begin
            $display("[ERROR] %0s r%0d expected %h actual %h",
                     caseName, r, expRegs[r], mirror[r]);
            bad++;
         end
      end
      if (retired != expCount) begin
         $display("[ERROR] %0s retired count expected %0d actual %0d",
                  caseName, expCount, retired);
         bad++;
      end
      if (sawErr && !expErr) begin
         $display("%0s: core raised err although every instruction was legal", caseName);
         bad++;
      end else if (!sawErr && expErr) begin
         $display("%0s: core never raised err for the illegal instruction", caseName);
         bad++;
      end
      if (bad == 0) begin
         $display("%0s: pass, %0d instructions retired", caseName, retired);
         passCount++;
      end else begin
         $display("%0s: FAIL with %0d mismatches", caseName, bad);
         failCount++;
      end
   endtask

   // Sampled at the rising edge, before the core's state updates land
   always @(posedge clk) begin
      if (reset) begin
         for (int r = 0; r < 8; r++) begin
            mirror[r] = '0;
         end
         retired = 0;
         traceBad = 0;
         sawErr = 1'b0;
         caseDone = 1'b0;
      end else if (halted) begin
         if (!caseDone) begin
            checkCase();
            caseDone = 1'b1;
         end
      end else begin
         if (err)
            sawErr = 1'b1;
         if (retire.valid) begin
            checkRecord();
            retired++;
            if (retire.regWrite)
               mirror[retire.regIndex] = retire.regData;
         end
      end
   end

endmodule

/* verif/coreCases.txt */
# case <name> <err expected 0/1>, then program words in hex from address 0
# expect <retired count, decimal> <r0> .. <r7> in hex, closing the case
case aluReg 0
C135 C21C D94C D951 D956 D95B D15D D443 0000
expect 9 000F 0035 001C 0051 FFE7 0029 0021 5000
# immediate ops, sign and zero extension
case aluImm 0
C146 415D 4965 519F 59B6 43D0 0000
expect 7 0000 0046 0043 FFBF 0059 0040 FFAF 0000
case lbiSlbi 0
C112 9134 C2AB 92CD C380 0000
expect 6 0000 1234 ABCD FF80 0000 0000 0000 0000
# stores at 0x40 and 0x44, loads back in swapped order
case memory 0
C112 9134 C29C C340 8320 8344 8B84 8BA0 43E6 8FDA 0000
expect 11 0000 1234 FF9C 0040 FF9C 1234 1234 0046
# r7 counts wrong-path instructions
case branches 0
C205 C3FF 6102 47E1 6202 6A02 47E1 6902 7302 47E1 7202 7A02 47E1 7B02 46C1 0000
expect 12 0000 0000 0005 FFFF 0000 0000 0001 0000
# JAL to a subroutine, JR back, countdown loop, J over the subroutine
case jumps 0
C103 3008 413F 4242 69FA 2004 C377 2F00 0000
expect 15 0000 0000 0006 0077 0000 0000 0000 0004
case illegal 1
C121 13E5 4141 0000
expect 4 0000 0021 0022 0000 0000 0000 0000 0000

/* verif/coreTb.sv */
/*
 * Testbench for the single-cycle core. Reads programs and expected
 * results from the cases file, loads each program during reset and
 * lets the checker judge the run after the core halts.
 */
module coreTb import isaPkg::*; ;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int maxCases = 8;
   localparam int maxWords = 16;
   localparam int resetCycles = 16;

   logic clk;
   logic reset;
   progLoadT progLoad;
   retireT retire;
   logic halted, err;

   logic [127:0] caseName;
   logic [maxWords-1:0][dataWidth-1:0] progExp;
   logic [7:0][dataWidth-1:0] expRegs;
   int expCount;
   logic expErr;
   logic caseDone;
   int passCount, failCount;

   logic [127:0] names [maxCases];
   logic expErrs [maxCases];
   int counts [maxCases];
   int lens [maxCases];
   logic [dataWidth-1:0] progs [maxCases][maxWords];
   logic [7:0][dataWidth-1:0] regsExp [maxCases];

   wiscCore dut0 (.clk(clk), .reset(reset), .progLoad(progLoad), .retire(retire),
      .halted(halted), .err(err));

   commitChecker retireCheck (.clk(clk), .reset(reset), .retire(retire), .halted(halted),
      .err(err), .caseName(caseName), .prog(progExp), .expRegs(expRegs),
      .expCount(expCount), .expErr(expErr), .caseDone(caseDone), .passCount(passCount),
      .failCount(failCount));

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // Program words go in one per reset cycle, then the core runs to HALT
   task automatic runCase(input int c);
      caseName = names[c];
      expErr = expErrs[c];
      expCount = counts[c];
      expRegs = regsExp[c];
      for (int i = 0; i < maxWords; i++) begin
         progExp[i] = (i < lens[c]) ? progs[c][i] : '0;
      end
      reset = 1'b1;
      for (int i = 0; i < resetCycles; i++) begin
         progLoad.valid = (i < lens[c]);
         progLoad.addr = memAddrWidth'(i);
         progLoad.data = (i < lens[c]) ? progs[c][i] : '0;
         @(negedge clk);
      end
      progLoad = '0;
      reset = 1'b0;
      while (!caseDone) @(negedge clk);
   endtask

   initial begin
      int fd, rc, nCases, cur, maxCount, limitCycles;
      logic [127:0] tok;
      logic [8*128-1:0] skipLine;
      logic [dataWidth-1:0] word;
      reset = 1'b1;
      progLoad = '0;
      caseName = '0;
      progExp = '0;
      expRegs = '0;
      expCount = 0;
      expErr = 1'b0;
      nCases = 0;
      cur = -1;
      maxCount = 0;

      fd = $fopen("verif/coreCases.txt", "r");
      if (fd == 0)
         $display("could not open verif/coreCases.txt, no cases were run");
      while (fd != 0 && $fscanf(fd, "%s", tok) == 1) begin
         if (tok == "#") begin
            rc = $fgets(skipLine, fd);
         end else if (tok == "case" && nCases < maxCases) begin
            cur = nCases;
            nCases++;
            rc = $fscanf(fd, "%s %d", names[cur], expErrs[cur]);
            lens[cur] = 0;
         end else if (tok == "expect" && cur >= 0) begin
            rc = $fscanf(fd, "%d", counts[cur]);
            if (counts[cur] > maxCount)
               maxCount = counts[cur];
            for (int r = 0; r < 8; r++) begin
               rc = $fscanf(fd, "%h", word);
               regsExp[cur][r] = word;
            end
         end else if (cur >= 0 && lens[cur] < maxWords) begin
            rc = $sscanf(tok, "%h", word);
            progs[cur][lens[cur]] = word;
            lens[cur]++;
         end
      end
      if (fd != 0)
         $fclose(fd);

      // Each case gets its reset, a generous run and some slack
      limitCycles = nCases * (resetCycles + 4 * maxCount + 20);
      fork
         begin
            #(limitCycles * 100 + 200);
            $display("timeout: core did not halt within %0d cycles, run hung", limitCycles);
            $display("sim failed");
            $finish;
         end
      join_none

      @(negedge clk);
      for (int c = 0; c < nCases; c++) begin
         runCase(c);
      end

      $display("cases passed %0d failed %0d", passCount, failCount);
      if (nCases > 0 && failCount == 0 && passCount == nCases) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule
